/* design/arcade_consts.svh */
// Constants for the arcade cabinet I/O block.
// Include wherever register addresses, game codes or timing limits are needed.
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// Wishbone word addresses
`define REG_GAME 2'd0
`define REG_OPT 2'd1
`define REG_DIP 2'd2

// Game selection codes
`define GAME_ROBOTRON 8'd0
`define GAME_JOUST 8'd1
`define GAME_BUBBLES 8'd3
`define GAME_SINISTAR 8'd6
`define GAME_PLAYBALL 8'd7

// Blanking limits, horizontal in half pixel counts and vertical in lines
`define HBLANK_START 10'd336
`define HBLANK_END 10'd40
`define VBLANK_START 11'd254
`define VBLANK_END 11'd14

// Analog stick band thresholds and the centred code
`define STICK_T1 32
`define STICK_T2 64
`define STICK_T3 96
`define STICK_CENTER 4'd7

`endif

/* design/arcade_pkg.sv */
// Shared types for the arcade cabinet I/O block.
// Referenced with scoped names by the RTL and the testbench.
`include "arcade_consts.svh"

package arcade_pkg;

	// Supported games, other codes map to released buses
	typedef enum logic [7:0]
	{
		game_robotron = `GAME_ROBOTRON,
		game_joust    = `GAME_JOUST,
		game_bubbles  = `GAME_BUBBLES,
		game_sinistar = `GAME_SINISTAR,
		game_playball = `GAME_PLAYBALL
	} game_e;

	// One player's digital pad, active high, right in bit 0
	typedef struct packed
	{
		logic spare;
		logic autoup;
		logic advance;
		logic coin;
		logic start2;
		logic start1;
		logic fire_f;
		logic fire_e;
		logic fire_d;
		logic fire_c;
		logic fire_b;
		logic fire_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_t;

	// Analog stick, x in the low byte
	typedef struct packed
	{
		logic signed [7:0] y;
		logic signed [7:0] x;
	} stick_t;

	typedef struct packed
	{
		logic [5:0] rsvd;
		logic       twin_stick;
		logic       fire_move;
	} opt_t;

	////////////////////////////////////////////////////////////
	// Wishbone classic bundles

	typedef struct packed
	{
		logic       cyc;
		logic       stb;
		logic       we;
		logic [1:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	typedef struct packed
	{
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	////////////////////////////////////////////////////////////
	// Cabinet side

	// ja, jb and the sinistar buttons are active low
	typedef struct packed
	{
		logic [7:0] ja;
		logic [7:0] jb;
		logic [2:0] btn;
		logic [7:0] sw;
		logic       sin_fire;
		logic       sin_bomb;
	} cab_ctrl_t;

	typedef struct packed
	{
		game_e      game;
		opt_t       opt;
		logic [7:0] dip;
	} cfg_t;

endpackage

/* design/wb_config_regs.sv */
// Configuration registers behind a Wishbone classic slave.
// Holds game code, control options and the first DIP byte for the control mapper.
`include "arcade_consts.svh"

module wb_config_regs
(
	input  logic                clk_sys,
	input  logic                rst_n,
	input  arcade_pkg::wb_req_t wb_req,
	output arcade_pkg::wb_rsp_t wb_rsp,
	output arcade_pkg::cfg_t    cfg
);

	logic [7:0]       game_q;
	arcade_pkg::opt_t opt_q;
	logic [7:0]       dip_q;
	logic             ack_q;
	logic [7:0]       rdat_q;
	logic             req_seen;

	// A request is taken only while no ack is pending, so ack stays one cycle wide
	assign req_seen = wb_req.cyc & wb_req.stb & ~ack_q;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			game_q <= '0;
			opt_q  <= '0;
			dip_q  <= '0;
			ack_q  <= 1'b0;
			rdat_q <= '0;
		end
		else
		begin
			ack_q <= req_seen;
			if (req_seen && wb_req.we)
			begin
				case (wb_req.adr)
					`REG_GAME: game_q <= wb_req.dat;
					`REG_OPT:  opt_q  <= arcade_pkg::opt_t'(wb_req.dat);
					`REG_DIP:  dip_q  <= wb_req.dat;
					default: ;
				endcase
			end
			if (req_seen && !wb_req.we)
			begin
				case (wb_req.adr)
					`REG_GAME: rdat_q <= game_q;
					`REG_OPT:  rdat_q <= opt_q;
					`REG_DIP:  rdat_q <= dip_q;
					default:   rdat_q <= '0;
				endcase
			end
		end
	end

	assign wb_rsp = '{ack: ack_q, dat: rdat_q};

	assign cfg = '{game: arcade_pkg::game_e'(game_q), opt: opt_q, dip: dip_q};

	// Single cycle ack, even when the master keeps stb high into the ack cycle
	ack_single_cycle: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack
	);

endmodule

/* design/stick_quantizer.sv */
// Analog stick to eight position code conversion for the twin stick game.
// Purely combinational, codes are 7 when the stick sits in the dead zone.
`include "arcade_consts.svh"

module stick_quantizer
(
	input  arcade_pkg::stick_t stick,
	output logic [3:0]         x_code,
	output logic [3:0]         y_code
);

	logic signed [8:0] x_ext;
	logic signed [8:0] y_neg;

	// Band lookup for the X axis
	function automatic logic [3:0] band(input logic signed [8:0] v);
		if (v < -`STICK_T3)
			return 4'd0;
		else if (v < -`STICK_T2)
			return 4'd4;
		else if (v < -`STICK_T1)
			return 4'd6;
		else if (v > `STICK_T3)
			return 4'd8;
		else if (v > `STICK_T2)
			return 4'd9;
		else if (v > `STICK_T1)
			return 4'd11;
		else
			return `STICK_CENTER;
	endfunction

	// Y uses the mirrored table, so negate with one extra bit to keep -128 exact
	assign x_ext = {stick.x[7], stick.x};
	assign y_neg = -{stick.y[7], stick.y};

	assign x_code = band(x_ext);
	assign y_code = band(y_neg);

endmodule

/* design/control_mapper.sv */
// Maps two players' pads and the active analog stick onto the cabinet buses.
// Outputs are registered, one clock after any pad, stick or config change.
`include "arcade_consts.svh"

module control_mapper
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  arcade_pkg::pad_t      pad1,
	input  arcade_pkg::pad_t      pad2,
	input  arcade_pkg::stick_t    stick1,
	input  arcade_pkg::stick_t    stick2,
	input  arcade_pkg::cfg_t      cfg,
	output arcade_pkg::cab_ctrl_t cab,
	output logic                  landscape
);

	arcade_pkg::pad_t      m;
	arcade_pkg::stick_t    stick_sel;
	arcade_pkg::cab_ctrl_t cab_d;
	logic                  p2_q;
	logic                  p2_d;
	logic                  landscape_d;
	logic [3:0]            ax;
	logic [3:0]            ay;
	logic [3:0]            dx;
	logic [3:0]            dy;
	logic [3:0]            hi_nib;
	logic [3:0]            lo_nib;

	// Direction nibble in cabinet order
	function automatic logic [3:0] rldu(input arcade_pkg::pad_t p);
		return {p.right, p.left, p.down, p.up};
	endfunction

	assign m = pad1 | pad2;

	////////////////////////////////////////////////////////////
	// Player tracking

	// Player 1 wins when both pads move in the same cycle
	always_comb
	begin
		if (|pad1)
			p2_d = 1'b0;
		else if (|pad2)
			p2_d = 1'b1;
		else
			p2_d = p2_q;
	end

	assign stick_sel = p2_d ? stick2 : stick1;

	stick_quantizer stick_quantizer_i
	(
		.stick  (stick_sel),
		.x_code (ax),
		.y_code (ay)
	);

	// Digital fallback for a centred stick
	assign dx = m.left ? 4'd0 : (m.right ? 4'd8 : `STICK_CENTER);
	assign dy = m.down ? 4'd0 : (m.up ? 4'd8 : `STICK_CENTER);

	////////////////////////////////////////////////////////////
	// Per game mapping

	assign lo_nib = cfg.opt.twin_stick ? rldu(pad1) : rldu(m);
	assign hi_nib = cfg.opt.twin_stick ? rldu(pad2) :
	                cfg.opt.fire_move  ? rldu(m)    :
	                {m.fire_a, m.fire_d, m.fire_b, m.fire_c};

	always_comb
	begin
		cab_d.sw       = cfg.dip | {6'b000000, m.advance, m.autoup};
		cab_d.sin_fire = ~m.fire_a;
		cab_d.sin_bomb = ~m.fire_b;
		cab_d.btn      = '0;
		cab_d.ja       = '1;
		cab_d.jb       = '1;
		landscape_d    = 1'b1;

		case (cfg.game)
			arcade_pkg::game_robotron:
			begin
				cab_d.btn = {m.start1, m.start2, m.coin};
				cab_d.ja  = ~{hi_nib, lo_nib};
				cab_d.jb  = ~{hi_nib, lo_nib};
			end
			arcade_pkg::game_joust:
			begin
				cab_d.btn = {m.start2, m.start1, m.coin};
				cab_d.ja  = ~{5'b00000, pad1.fire_a, pad1.right, pad1.left};
				cab_d.jb  = ~{5'b00000, pad2.fire_a, pad2.right, pad2.left};
			end
			arcade_pkg::game_bubbles:
			begin
				cab_d.btn = {m.start2, m.start1, m.coin};
				cab_d.ja  = ~{4'b0000, rldu(m)};
				cab_d.jb  = ~{4'b0000, rldu(m)};
			end
			arcade_pkg::game_sinistar:
			begin
				landscape_d = 1'b0;
				cab_d.btn   = {m.start1, m.start2, m.coin};
				cab_d.ja    = ~{(ax == `STICK_CENTER) ? dx : ax, (ay == `STICK_CENTER) ? dy : ay};
				cab_d.jb    = cab_d.ja;
			end
			arcade_pkg::game_playball:
			begin
				landscape_d = 1'b0;
				cab_d.btn   = {2'b00, m.coin};
				cab_d.ja    = ~{4'b0000, m.start2, m.right, m.left, m.start1};
				cab_d.jb    = cab_d.ja;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p2_q      <= 1'b0;
			cab       <= '{ja: '1, jb: '1, btn: '0, sw: '0, sin_fire: 1'b1, sin_bomb: 1'b1};
			landscape <= 1'b1;
		end
		else
		begin
			p2_q      <= p2_d;
			cab       <= cab_d;
			landscape <= landscape_d;
		end
	end

	// Only joust drives the two joystick ports separately
	shared_ports: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(cfg.game != arcade_pkg::game_joust) |=> (cab.ja == cab.jb)
	);

endmodule

/* design/blank_gen.sv */
// Rebuilds horizontal and vertical blanking from the game core's sync pulses.
// Also derives the pixel clock enable from the pixel counter.
`include "arcade_consts.svh"

module blank_gen
(
	input  logic clk_sys,
	input  logic rst_n,
	input  logic hsync,
	input  logic vsync,
	output logic hblank,
	output logic vblank,
	output logic ce_pix
);

	logic [10:0] pcnt;
	logic [10:0] lcnt;
	logic [10:0] lcnt_d;
	logic        hs_q;
	logic        vs_q;
	logic        hs_rise;

	assign hs_rise = hsync & ~hs_q;

	// vsync is only looked at on hsync edges, new frame when it rose in between
	assign lcnt_d = (vsync & ~vs_q) ? 11'd0 : ((&lcnt) ? lcnt : lcnt + 11'd1);

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pcnt   <= '0;
			lcnt   <= '0;
			hs_q   <= 1'b0;
			vs_q   <= 1'b0;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end
		else
		begin
			hs_q <= hsync;
			if (hs_rise)
			begin
				pcnt <= '0;
				lcnt <= lcnt_d;
				vs_q <= vsync;
				// Vertical blanking moves together with the line count
				if (lcnt_d == `VBLANK_START)
					vblank <= 1'b1;
				else if (lcnt_d == `VBLANK_END)
					vblank <= 1'b0;
			end
			else if (!(&pcnt))
				pcnt <= pcnt + 11'd1;

			if (pcnt[10:1] == `HBLANK_START)
				hblank <= 1'b1;
			else if (pcnt[10:1] == `HBLANK_END)
				hblank <= 1'b0;
		end
	end

	assign ce_pix = pcnt[0];

	vblank_on_line_edge: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		$changed(vblank) |-> $past(hs_rise)
	);

endmodule

/* design/arcade_io_top.sv */
// Top level of the cabinet I/O block.
// Host config over Wishbone, pad mapping to cabinet buses and blanking rebuild.

module arcade_io_top
(
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  arcade_pkg::wb_req_t   wb_req,
	output arcade_pkg::wb_rsp_t   wb_rsp,
	input  arcade_pkg::pad_t      pad1,
	input  arcade_pkg::pad_t      pad2,
	input  arcade_pkg::stick_t    stick1,
	input  arcade_pkg::stick_t    stick2,
	input  logic                  hsync,
	input  logic                  vsync,
	output arcade_pkg::cab_ctrl_t cab,
	output logic                  landscape,
	output logic                  hblank,
	output logic                  vblank,
	output logic                  ce_pix
);

	arcade_pkg::cfg_t cfg;

	wb_config_regs wb_config_regs_i
	(
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.cfg     (cfg)
	);

	control_mapper control_mapper_i
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.pad1      (pad1),
		.pad2      (pad2),
		.stick1    (stick1),
		.stick2    (stick2),
		.cfg       (cfg),
		.cab       (cab),
		.landscape (landscape)
	);

	blank_gen blank_gen_i
	(
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.hsync   (hsync),
		.vsync   (vsync),
		.hblank  (hblank),
		.vblank  (vblank),
		.ce_pix  (ce_pix)
	);

endmodule

/* verification/arcade_io_tb.sv */
// Testbench for the cabinet I/O block.
// Drives Wishbone setup, random pads and sticks and synthetic sync, and checks the
// DUT against a reference model with concurrent assertions.
`include "arcade_consts.svh"

module arcade_io_tb;

	logic                  clk_sys = 1'b0;
	logic                  rst_n;
	arcade_pkg::wb_req_t   wb_req;
	arcade_pkg::wb_rsp_t   wb_rsp;
	arcade_pkg::pad_t      pad1;
	arcade_pkg::pad_t      pad2;
	arcade_pkg::stick_t    stick1;
	arcade_pkg::stick_t    stick2;
	logic                  hsync;
	logic                  vsync;
	arcade_pkg::cab_ctrl_t cab;
	logic                  landscape;
	logic                  hblank;
	logic                  vblank;
	logic                  ce_pix;

	// Model state and run bookkeeping
	logic [31:0]      rng;
	logic [7:0]       m_game;
	arcade_pkg::opt_t m_opt;
	logic [7:0]       m_dip;
	logic             p2_m;
	logic             p2_nx;
	logic [29:0]      exp_now;
	logic [29:0]      exp_q;
	logic             chk_en;
	logic             rd_pend;
	logic [7:0]       exp_rd;
	logic             timed_out;
	int               err_cnt;
	int               err_mark;
	int               tests_run;
	int               tests_failed;

	// Blanking monitor
	logic        hs_prev;
	logic        vs_prev;
	logic        hs_rise_tb;
	logic        vs_rise_tb;
	logic [10:0] pix_m;
	int          hlo_cnt;
	int          vlo_cnt;
	int          lines_seen;
	int          frames_seen;

	arcade_io_top arcade_io_top_i
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.pad1      (pad1),
		.pad2      (pad2),
		.stick1    (stick1),
		.stick2    (stick2),
		.hsync     (hsync),
		.vsync     (vsync),
		.cab       (cab),
		.landscape (landscape),
		.hblank    (hblank),
		.vblank    (vblank),
		.ce_pix    (ce_pix)
	);

	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [3:0] quant_x(input int v);
		if (v < -`STICK_T3)
			return 4'd0;
		else if (v < -`STICK_T2)
			return 4'd4;
		else if (v < -`STICK_T1)
			return 4'd6;
		else if (v > `STICK_T3)
			return 4'd8;
		else if (v > `STICK_T2)
			return 4'd9;
		else if (v > `STICK_T1)
			return 4'd11;
		return 4'd7;
	endfunction

	// Mirrored table, pushing the stick down gives the low codes
	function automatic logic [3:0] quant_y(input int v);
		if (v < -`STICK_T3)
			return 4'd8;
		else if (v < -`STICK_T2)
			return 4'd9;
		else if (v < -`STICK_T1)
			return 4'd11;
		else if (v > `STICK_T3)
			return 4'd0;
		else if (v > `STICK_T2)
			return 4'd4;
		else if (v > `STICK_T1)
			return 4'd6;
		return 4'd7;
	endfunction

	// Returns landscape above the cabinet buses
	function automatic logic [29:0] expect_io(
		input arcade_pkg::pad_t   a,
		input arcade_pkg::pad_t   b,
		input arcade_pkg::stick_t s,
		input logic [7:0]         game,
		input arcade_pkg::opt_t   opt,
		input logic [7:0]         dip
	);
		arcade_pkg::pad_t      m;
		arcade_pkg::cab_ctrl_t c;
		logic                  land;
		logic [3:0]            hi;
		logic [3:0]            lo;
		logic [3:0]            qx;
		logic [3:0]            qy;
		m = a | b;
		c.sw = dip | {6'd0, m.advance, m.autoup};
		c.sin_fire = ~m.fire_a;
		c.sin_bomb = ~m.fire_b;
		c.btn = 3'b000;
		c.ja = 8'hff;
		c.jb = 8'hff;
		land = 1'b1;
		if (game == `GAME_ROBOTRON)
		begin
			if (opt.twin_stick)
				lo = {a.right, a.left, a.down, a.up};
			else
				lo = {m.right, m.left, m.down, m.up};
			if (opt.twin_stick)
				hi = {b.right, b.left, b.down, b.up};
			else if (opt.fire_move)
				hi = {m.right, m.left, m.down, m.up};
			else
				hi = {m.fire_a, m.fire_d, m.fire_b, m.fire_c};
			c.btn = {m.start1, m.start2, m.coin};
			c.ja = ~{hi, lo};
			c.jb = c.ja;
		end
		else if (game == `GAME_JOUST)
		begin
			c.btn = {m.start2, m.start1, m.coin};
			c.ja = ~{5'd0, a.fire_a, a.right, a.left};
			c.jb = ~{5'd0, b.fire_a, b.right, b.left};
		end
		else if (game == `GAME_BUBBLES)
		begin
			c.btn = {m.start2, m.start1, m.coin};
			c.ja = ~{4'd0, m.right, m.left, m.down, m.up};
			c.jb = c.ja;
		end
		else if (game == `GAME_SINISTAR)
		begin
			land = 1'b0;
			c.btn = {m.start1, m.start2, m.coin};
			qx = quant_x(int'(s.x));
			qy = quant_y(int'(s.y));
			if (qx == 4'd7)
				qx = m.left ? 4'd0 : (m.right ? 4'd8 : 4'd7);
			if (qy == 4'd7)
				qy = m.down ? 4'd0 : (m.up ? 4'd8 : 4'd7);
			c.ja = ~{qx, qy};
			c.jb = c.ja;
		end
		else if (game == `GAME_PLAYBALL)
		begin
			land = 1'b0;
			c.btn = {2'b00, m.coin};
			c.ja = ~{4'd0, m.start2, m.right, m.left, m.start1};
			c.jb = c.ja;
		end
		return {land, c};
	endfunction

	// Last active player, pad 1 first
	assign p2_nx = (|pad1) ? 1'b0 : ((|pad2) ? 1'b1 : p2_m);
	assign exp_now = expect_io(pad1, pad2, p2_nx ? stick2 : stick1, m_game, m_opt, m_dip);

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			p2_m <= 1'b0;
		else
			p2_m <= p2_nx;
	end

	always_ff @(posedge clk_sys)
	begin
		exp_q <= exp_now;
	end

	////////////////////////////////////////////////////////////
	// Blanking monitor, counts per line and per frame

	assign hs_rise_tb = hsync & ~hs_prev;
	assign vs_rise_tb = vsync & ~vs_prev;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hs_prev     <= 1'b0;
			vs_prev     <= 1'b0;
			pix_m       <= '0;
			hlo_cnt     <= 0;
			vlo_cnt     <= 0;
			lines_seen  <= 0;
			frames_seen <= 0;
		end
		else
		begin
			hs_prev <= hsync;
			vs_prev <= vsync;
			// Pixel count clears on the line edge and sticks at all ones
			if (hs_rise_tb)
				pix_m <= '0;
			else if (pix_m != 11'h7ff)
				pix_m <= pix_m + 11'd1;
			if (hs_rise_tb)
			begin
				hlo_cnt <= 0;
				if (lines_seen < 3)
					lines_seen <= lines_seen + 1;
				if (vs_rise_tb)
				begin
					vlo_cnt <= vblank ? 0 : 1;
					if (frames_seen < 3)
						frames_seen <= frames_seen + 1;
				end
				else
					vlo_cnt <= vlo_cnt + (vblank ? 0 : 1);
			end
			else if (!hblank)
				hlo_cnt <= hlo_cnt + 1;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks

	ack_one_cycle: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		wb_rsp.ack |=> !wb_rsp.ack
	)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: ack held for more than one cycle", $time);
	end

	read_data: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(rd_pend && wb_rsp.ack) |-> (wb_rsp.dat == exp_rd)
	)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: read data %h, expected %h", $time, $sampled(wb_rsp.dat),
		         $sampled(exp_rd));
	end

	cab_model: assert property (
		@(posedge clk_sys) disable iff (!chk_en)
		cab == exp_q[28:0]
	)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: cab %h, expected %h", $time, $sampled(cab),
		         $sampled(exp_q[28:0]));
	end

	landscape_model: assert property (
		@(posedge clk_sys) disable iff (!chk_en)
		landscape == exp_q[29]
	)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: landscape %b, expected %b", $time, $sampled(landscape),
		         $sampled(exp_q[29]));
	end

	pixel_enable: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		ce_pix == pix_m[0]
	)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: ce_pix %b, expected %b", $time, $sampled(ce_pix),
		         $sampled(pix_m[0]));
	end

	// The first line and frame start from reset state and are skipped
	hblank_width: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(hs_rise_tb && lines_seen >= 2) |-> (hlo_cnt == 592)
	)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: %0d cycles without hblank, expected 592", $time,
		         $sampled(hlo_cnt));
	end

	vblank_height: assert property (
		@(posedge clk_sys) disable iff (!rst_n)
		(vs_rise_tb && frames_seen >= 2) |-> (vlo_cnt == 240)
	)
	else
	begin
		err_cnt++;
		$display("FAIL %0t: %0d lines without vblank, expected 240", $time,
		         $sampled(vlo_cnt));
	end

	////////////////////////////////////////////////////////////
	// Stimulus helpers

	function automatic logic [15:0] next_rand();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng[30:15];
	endfunction

	// A quarter of the draws idle, so the tracked player has to be held
	function automatic arcade_pkg::pad_t rand_pad();
		logic [15:0] r;
		r = next_rand();
		if (r[1:0] == 2'd0)
			return '0;
		return arcade_pkg::pad_t'(next_rand());
	endfunction

	function automatic arcade_pkg::stick_t rand_stick(input logic centred);
		arcade_pkg::stick_t s;
		s = arcade_pkg::stick_t'(next_rand());
		if (centred && s.x[0])
		begin
			s.x = {{3{s.x[7]}}, s.x[7:3]};
			s.y = {{3{s.y[7]}}, s.y[7:3]};
		end
		return s;
	endfunction

	// Returns one unit after the edge that shows ack, with the request still on the bus
	task automatic wait_ack();
		int n;
		n = 0;
		@(posedge clk_sys);
		#1;
		while (!wb_rsp.ack && n < 20)
		begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (!wb_rsp.ack)
		begin
			timed_out = 1'b1;
			err_cnt++;
			$display("Timeout at %0t: no Wishbone ack within 20 cycles", $time);
		end
	endtask

	// The master samples ack on the next edge and only then releases the bus
	task automatic end_cycle();
		@(posedge clk_sys);
		#1;
		wb_req = '0;
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [7:0] dat);
		rd_pend = 1'b0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		wait_ack();
		// The DUT took the write on the ack edge
		case (adr)
			`REG_GAME: m_game = dat;
			`REG_OPT:  m_opt = dat;
			`REG_DIP:  m_dip = dat;
			default: ;
		endcase
		end_cycle();
	endtask

	task automatic read_reg(input logic [1:0] adr, input logic [7:0] expected);
		rd_pend = 1'b1;
		exp_rd = expected;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
		wait_ack();
		end_cycle();
	endtask

	task automatic drive_random(input int cycles, input logic centred);
		repeat (cycles)
		begin
			@(posedge clk_sys);
			#1;
			pad1 = rand_pad();
			pad2 = rand_pad();
			stick1 = rand_stick(centred);
			stick2 = rand_stick(centred);
		end
	endtask

	// 848 clocks per line, 260 lines per frame, vsync over the first 3 lines
	task automatic run_sync(input int frames);
		for (int f = 0; f < frames; f++)
			for (int ln = 0; ln < 260; ln++)
				for (int c = 0; c < 848; c++)
				begin
					@(posedge clk_sys);
					#1;
					hsync = (c < 64);
					vsync = (ln < 3);
				end
		// Start one more frame so the last full one is closed
		@(posedge clk_sys);
		#1;
		hsync = 1'b1;
		vsync = 1'b1;
		repeat (4) @(posedge clk_sys);
		#1;
		hsync = 1'b0;
		vsync = 1'b0;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (err_cnt == err_mark)
			$display("%s: ok", name);
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, err_cnt - err_mark);
		end
		err_mark = err_cnt;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence

	initial
	begin
		rng = 32'd2;
		rst_n = 1'b0;
		wb_req = '0;
		pad1 = '0;
		pad2 = '0;
		stick1 = '0;
		stick2 = '0;
		hsync = 1'b0;
		vsync = 1'b0;
		m_game = 8'd0;
		m_opt = '0;
		m_dip = 8'd0;
		chk_en = 1'b0;
		rd_pend = 1'b0;
		exp_rd = 8'd0;
		timed_out = 1'b0;
		err_cnt = 0;
		err_mark = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (4) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		chk_en = 1'b1;

		write_reg(`REG_GAME, `GAME_BUBBLES);
		write_reg(`REG_OPT, 8'h02);
		write_reg(`REG_DIP, 8'ha5);
		write_reg(2'd3, 8'hff);
		read_reg(`REG_GAME, `GAME_BUBBLES);
		read_reg(`REG_OPT, 8'h02);
		read_reg(`REG_DIP, 8'ha5);
		read_reg(2'd3, 8'h00);
		finish_test("wishbone");

		write_reg(`REG_OPT, 8'h00);
		write_reg(`REG_DIP, 8'h00);
		write_reg(`REG_GAME, `GAME_JOUST);
		drive_random(200, 1'b0);
		finish_test("joust");

		write_reg(`REG_GAME, `GAME_BUBBLES);
		drive_random(200, 1'b0);
		finish_test("bubbles");

		write_reg(`REG_GAME, `GAME_ROBOTRON);
		for (int o = 0; o < 4; o++)
		begin
			write_reg(`REG_OPT, 8'(o));
			drive_random(150, 1'b0);
		end
		finish_test("robotron");

		write_reg(`REG_OPT, 8'h00);
		write_reg(`REG_GAME, `GAME_SINISTAR);
		drive_random(400, 1'b1);
		finish_test("sinistar");

		write_reg(`REG_GAME, `GAME_PLAYBALL);
		drive_random(200, 1'b0);
		finish_test("playball");

		// Every code, unsupported ones included
		for (int g = 0; g < 8; g++)
		begin
			write_reg(`REG_GAME, 8'(g));
			write_reg(`REG_DIP, 8'(next_rand()));
			drive_random(60, 1'b0);
		end
		finish_test("switches");

		run_sync(3);
		finish_test("blanking");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && !timed_out)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* list.f */
+incdir+design
design/arcade_pkg.sv
design/wb_config_regs.sv
design/stick_quantizer.sv
design/control_mapper.sv
design/blank_gen.sv
design/arcade_io_top.sv
verification/arcade_io_tb.sv

/* Makefile */
# Verilator build for the cabinet I/O block
TOP = arcade_io_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then \
		echo "Simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
